//--- bench/ts_model.svh
`ifndef TS_MODEL_SVH
`define TS_MODEL_SVH

// xorshift32 step, never returns zero for a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// value a slot holds just before edge t, when v was loaded at edge w
// ticks land on every edge that is a multiple of the period
function automatic logic [32:0] pts_at_edge(input logic [32:0] v, input int w, input int t,
	input int period);
	return v + 33'((t - 1) / period - w / period);
endfunction

// byte n of a packet inside its 32-bit memory word
function automatic logic [7:0] word_byte(input logic [31:0] word, input int n);
	return word[8 * (n % 4) +: 8];
endfunction

// replacement byte at position n of an accepted packet
function automatic logic [7:0] expected_byte(input int n, input logic [7:0] in_b,
	input logic [7:0] mem_b, input logic change, input logic pts_on, input logic [32:0] pts);
	logic [7:0] b;
	b = mem_b;
	if (pts_on && n >= pts_first_byte && n < pts_first_byte + 5) begin
		case (n - pts_first_byte)
			0: b = {4'b0010, pts[32:30], 1'b1};
			1: b = pts[29:22];
			2: b = {pts[21:15], 1'b1};
			3: b = pts[14:7];
			default: b = {pts[8:2], 1'b1};
		endcase
	end else if (n == 1) begin
		// error and priority bits from the live stream
		b = {in_b[7], mem_b[6], in_b[5], change ? mem_b[4:0] : in_b[4:0]};
	end else if (n == 2) begin
		b = change ? mem_b : in_b;
	end else if (n == 3) begin
		// continuity counter stays with the stream
		b = {mem_b[7:4], in_b[3:0]};
	end
	return b;
endfunction

`endif

//--- bench/tb_ts_replacer.sv
`timescale 1ns/1ps

module tb_ts_replacer import ts_replace_pkg::*; ();

	localparam int slots = 4;
	localparam int groups = 2;
	localparam int pts_period = 50;
	localparam int words = pkt_words * groups;
	localparam int total_pkts = 34;
	localparam int clk_period = 100;

	`include "ts_model.svh"

	logic clk;
	logic rst_n;
	logic cfg_write;
	logic [1:0] cfg_index;
	logic [31:0] cfg_word;
	logic pts_write;
	logic [1:0] pts_index;
	logic [32:0] pts_value;
	logic data_write;
	logic [6:0] data_index;
	logic [31:0] data_word;
	logic match_enable;
	logic base_data;
	logic [7:0] ts_data;
	logic ts_valid;
	logic ts_sync;
	logic [7:0] ts_out;
	logic ts_out_valid;
	logic ts_out_sync;
	logic matched_state;
	logic [31:0] matched_count;

	// reference model state
	logic [31:0] rng;
	logic [31:0] mem_m [words];
	pid_cfg_u cfg_m [slots];
	int grp_m [slots];
	logic [32:0] pts_val_m [slots];
	int pts_edge_m [slots];
	logic [12:0] pid_pool [6];
	logic [7:0] pkt_buf [pkt_bytes];
	logic [8:0] hist [3];
	logic [8:0] exp_q [$];
	int accepted_m;
	logic hit_m;
	int edge_cnt = 0;
	int compared = 0;
	int out_errors = 0;
	int status_errors = 0;

	ts_replacer_top #(
		.PID_SLOTS(slots),
		.DATA_GROUPS(groups),
		.PTS_PERIOD(pts_period)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_write(cfg_write),
		.cfg_index(cfg_index),
		.cfg_word(cfg_word),
		.pts_write(pts_write),
		.pts_index(pts_index),
		.pts_value(pts_value),
		.data_write(data_write),
		.data_index(data_index),
		.data_word(data_word),
		.match_enable(match_enable),
		.base_data(base_data),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid),
		.ts_out_sync(ts_out_sync),
		.matched_state(matched_state),
		.matched_count(matched_count)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// edges seen out of reset, used for the PTS tick model
	always @(posedge clk) begin
		if (rst_n) begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	// outputs settle after the rising edge, compare them in the low phase
	always @(negedge clk) begin : check_out
		logic [8:0] want;
		if (rst_n && ts_out_valid) begin
			assert (exp_q.size() != 0) else begin
				out_errors++;
				$display("output byte %h came out when none was expected, time %0t",
					ts_out, $time);
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				compared++;
				assert ({ts_out_sync, ts_out} == want) else begin
					out_errors++;
					$display("Error at time %0t: output %h sync %b, expected %h sync %b",
						$time, ts_out, ts_out_sync, want[7:0], want[8]);
				end
			end
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic draw(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	task automatic load_word(input int idx, input logic [31:0] w);
		data_write = 1'b1;
		data_index = 7'(idx);
		data_word = w;
		mem_m[idx] = w;
		step();
		data_write = 1'b0;
	endtask

	// flags are pts_insert, change_pid, match_en; padding gets random bits
	task automatic load_cfg(input int idx, input logic [12:0] pid, input logic [2:0] flags);
		pid_cfg_u c;
		logic [31:0] r;
		draw(r);
		c.raw = r;
		c.f.pid = pid;
		{c.f.pts_insert, c.f.change_pid, c.f.match_en} = flags;
		cfg_m[idx] = c;
		cfg_write = 1'b1;
		cfg_index = 2'(idx);
		cfg_word = c.raw;
		step();
		cfg_write = 1'b0;
	endtask

	task automatic load_pts(input int idx, input logic [32:0] v);
		pts_write = 1'b1;
		pts_index = 2'(idx);
		pts_value = v;
		pts_val_m[idx] = v;
		pts_edge_m[idx] = edge_cnt + 1;
		step();
		pts_write = 1'b0;
	endtask

	task automatic drive_byte(input logic [7:0] b, input logic sync);
		// pass-through repeats the input from three valid bytes back
		if (base_data) begin
			exp_q.push_back(hist[2]);
		end
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = {sync, b};
		ts_valid = 1'b1;
		ts_data = b;
		ts_sync = sync;
		step();
		ts_valid = 1'b0;
	endtask

	// decision for the packet in pkt_buf, taken on the edge that samples byte 2
	task automatic predict_packet();
		logic [12:0] pid;
		logic [32:0] pts;
		logic [31:0] w;
		logic pts_on;
		int s;
		int g;
		pid = {pkt_buf[1][4:0], pkt_buf[2]};
		s = -1;
		for (int i = 0; i < slots; i++) begin
			if (((cfg_m[i].f.match_en && match_enable) || grp_m[i] != 0) &&
				cfg_m[i].f.pid == pid) begin
				s = i;
			end
		end
		hit_m = (s >= 0);
		if (s >= 0) begin
			g = grp_m[s];
			grp_m[s] = (g + 1) % groups;
			accepted_m++;
			pts = pts_at_edge(pts_val_m[s], pts_edge_m[s], edge_cnt + 1, pts_period);
			pts_on = cfg_m[s].f.pts_insert && g == 0;
			for (int n = 0; n < pkt_bytes; n++) begin
				w = mem_m[7'(g * pkt_words + n / 4)];
				exp_q.push_back({n == 0, expected_byte(n, pkt_buf[n], word_byte(w, n),
					cfg_m[s].f.change_pid, pts_on, pts)});
			end
		end
	endtask

	// a hit enters the matched state, a miss leaves it
	task automatic check_state(input logic want);
		assert (matched_state == want) else begin
			status_errors++;
			$display("Error at time %0t: matched_state %b, expected %b",
				$time, matched_state, want);
		end
	endtask

	task automatic send_packet(input logic [12:0] pid);
		logic [31:0] r;
		pkt_buf[0] = sync_byte;
		draw(r);
		pkt_buf[1] = {r[7:5], pid[12:8]};
		pkt_buf[2] = pid[7:0];
		for (int i = 3; i < pkt_bytes; i++) begin
			draw(r);
			pkt_buf[i] = r[15:8];
		end
		for (int i = 0; i < pkt_bytes; i++) begin
			// random gaps in ts_valid
			draw(r);
			while (r[1:0] == 2'b00) begin
				step();
				draw(r);
			end
			if (i == 2 && !base_data) begin
				predict_packet();
			end
			drive_byte(pkt_buf[i], i == 0);
			if (i == 2 && !base_data) begin
				check_state(hit_m);
			end
		end
	endtask

	task automatic send_random(input int count);
		logic [31:0] r;
		for (int k = 0; k < count; k++) begin
			draw(r);
			send_packet(pid_pool[3'(r % 6)]);
		end
	endtask

	task automatic check_count();
		assert (matched_count == 32'(accepted_m)) else begin
			status_errors++;
			$display("Error at time %0t: matched_count %0d, expected %0d",
				$time, matched_count, accepted_m);
		end
	endtask

	initial begin : stimulus
		logic [31:0] r;
		rng = 32'h5ab2_9c97;
		rst_n = 1'b0;
		cfg_write = 1'b0;
		cfg_index = '0;
		cfg_word = '0;
		pts_write = 1'b0;
		pts_index = '0;
		pts_value = '0;
		data_write = 1'b0;
		data_index = '0;
		data_word = '0;
		match_enable = 1'b0;
		base_data = 1'b0;
		ts_data = '0;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		accepted_m = 0;
		hit_m = 1'b0;
		for (int i = 0; i < slots; i++) begin
			cfg_m[i].raw = '0;
			grp_m[i] = 0;
			pts_val_m[i] = '0;
			pts_edge_m[i] = 0;
		end
		for (int i = 0; i < 3; i++) begin
			hist[i] = '0;
		end
		// 13'h1fff and 13'h0777 never match a slot
		pid_pool[0] = 13'h0101;
		pid_pool[1] = 13'h0202;
		pid_pool[2] = 13'h0303;
		pid_pool[3] = 13'h0404;
		pid_pool[4] = 13'h1fff;
		pid_pool[5] = 13'h0777;

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < words; i++) begin
			draw(r);
			load_word(i, r);
		end
		load_cfg(0, 13'h0101, 3'b001);
		load_cfg(1, 13'h0202, 3'b011);
		load_cfg(2, 13'h0303, 3'b111);
		// slot 3 is disabled
		load_cfg(3, 13'h0404, 3'b100);
		draw(r);
		load_pts(2, {1'b1, r});
		draw(r);
		load_pts(3, {1'b0, r});
		match_enable = 1'b1;

		// one slot back to back, groups alternate and PTS only in group 0
		repeat (4) send_packet(13'h0303);
		draw(r);
		load_pts(2, {r[0], r});
		send_random(12);
		send_packet(13'h1fff);
		check_count();

		// slot 0 mid rotation, then match_enable drops
		while (grp_m[0] == 0) begin
			send_packet(13'h0101);
		end
		match_enable = 1'b0;
		send_packet(13'h0101);
		send_packet(13'h0101);
		send_random(6);
		send_packet(13'h1fff);
		check_count();

		// pass-through of the raw stream
		base_data = 1'b1;
		send_random(3);
		repeat (2) step();
		base_data = 1'b0;
		step();

		// back to replacing after pass-through
		match_enable = 1'b1;
		send_random(3);
		send_packet(13'h1fff);
		repeat (4) step();
		check_count();

		assert (exp_q.size() == 0) else begin
			status_errors++;
			$display("%0d expected output bytes never came out", exp_q.size());
		end
		$display("summary: %0d bytes compared, %0d output errors, %0d status errors",
			compared, out_errors, status_errors);
		if (out_errors + status_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// at most four cycles per stream byte
	initial begin : watchdog
		repeat (total_pkts * pkt_bytes * 4) @(posedge clk);
		$display("watchdog expired after %0d cycles, the stimulus did not finish",
			total_pkts * pkt_bytes * 4);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- common/pid_match_if.sv
`timescale 1ns/1ps

interface pid_match_if import ts_replace_pkg::*; #(
	parameter int PID_SLOTS = 4
) ();

	localparam int slot_w = (PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1;

	// match result for the candidate PID
	logic hit;
	logic [slot_w-1:0] slot;
	logic change_pid;
	logic pts_insert;
	logic [grp_w-1:0] group;

	// candidate PID bytes and the accept strobe
	logic [7:0] pid_hi;
	logic [7:0] pid_lo;
	logic accept;

	modport tbl (
		input pid_hi, pid_lo, accept,
		output hit, slot, change_pid, pts_insert, group
	);

	modport fsm (
		input hit, slot, change_pid, pts_insert, group,
		output pid_hi, pid_lo, accept
	);

endinterface

//--- common/ts_replace_pkg.sv
package ts_replace_pkg;

	// packet geometry
	localparam int pkt_bytes = 188;
	localparam int pkt_words = 47;
	localparam logic [7:0] sync_byte = 8'h47;

	// field widths
	localparam int pid_w = 13;
	localparam int data_w = 32;
	localparam int pts_w = 33;

	// five PTS marker bytes start here in group 0
	localparam int pts_first_byte = 24;

	// position counts 0..188, group counters wrap below 256
	localparam int pos_w = 8;
	localparam int grp_w = 8;

	// slot configuration word, written whole by the host and decoded per field
	typedef union packed {
		logic [data_w-1:0] raw;
		struct packed {
			logic [12:0] pad_hi;
			logic pts_insert;
			logic change_pid;
			logic match_en;
			logic [2:0] pad_lo;
			logic [pid_w-1:0] pid;
		} f;
	} pid_cfg_u;

endpackage

//--- replace_engine/byte_rewriter.sv
`timescale 1ns/1ps

module byte_rewriter import ts_replace_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] ts_data,
	input logic ts_valid,
	input logic ts_sync,
	input logic [pos_w-1:0] position,
	input logic emit,
	input logic base_data,
	input logic change_pid,
	input logic pts_insert,
	input logic [grp_w-1:0] group,
	input logic [pts_w-1:0] pts_latched,
	input logic [7:0] ram_byte,
	output logic sync_d2,
	output logic [7:0] data_d2,
	output logic [7:0] data_d1,
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync
);

	logic sync_d1;
	logic sync_d3;
	logic [7:0] data_d3;

	logic in_pts;
	logic [pos_w-1:0] pts_sel;
	logic [7:0] rule_byte;

	// three-byte delay line, shifted only on valid input
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			sync_d3 <= 1'b0;
		end else if (ts_valid) begin
			sync_d1 <= ts_sync;
			sync_d2 <= sync_d1;
			sync_d3 <= sync_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (ts_valid) begin
			data_d1 <= ts_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	// PTS window covers five bytes, group 0 only
	assign in_pts = pts_insert && (group == '0) &&
		(position >= pos_w'(pts_first_byte)) && (position < pos_w'(pts_first_byte + 5));
	assign pts_sel = position - pos_w'(pts_first_byte);

	always_comb begin
		rule_byte = ram_byte;
		if (in_pts) begin
			case (pts_sel)
				pos_w'(0): rule_byte = {4'b0010, pts_latched[32:30], 1'b1};
				pos_w'(1): rule_byte = pts_latched[29:22];
				pos_w'(2): rule_byte = {pts_latched[21:15], 1'b1};
				pos_w'(3): rule_byte = pts_latched[14:7];
				default: rule_byte = {pts_latched[8:2], 1'b1};
			endcase
		end else begin
			case (position)
				// error and priority bits stay, start indicator from memory
				pos_w'(1): rule_byte = {data_d3[7], ram_byte[6], data_d3[5],
					change_pid ? ram_byte[4:0] : data_d3[4:0]};
				pos_w'(2): rule_byte = change_pid ? ram_byte : data_d3;
				// scrambling and adaptation bits replaced, continuity counter kept
				pos_w'(3): rule_byte = {ram_byte[7:4], data_d3[3:0]};
				default: rule_byte = ram_byte;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
		end else begin
			ts_out_valid <= ts_valid && emit;
			if (ts_valid && emit) begin
				ts_out_sync <= sync_d3;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ts_valid && emit) begin
			ts_out <= base_data ? data_d3 : rule_byte;
		end
	end

endmodule

//--- replace_engine/packet_fsm.sv
`timescale 1ns/1ps

module packet_fsm import ts_replace_pkg::*; #(
	parameter int DATA_GROUPS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic ts_valid,
	input logic base_data,
	input logic sync_d2,
	input logic [7:0] data_d2,
	input logic [7:0] data_d1,
	input logic [7:0] ts_data,
	input logic [pts_w-1:0] slot_pts,
	output logic [pos_w-1:0] position,
	output logic emit,
	output logic matched,
	output logic change_pid,
	output logic pts_insert,
	output logic [grp_w-1:0] group,
	output logic [pts_w-1:0] pts_latched,
	output logic [data_w-1:0] matched_count,
	pid_match_if.fsm pm
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_match = 2'd1;
	localparam logic [1:0] st_pass = 2'd2;

	logic [1:0] state;
	logic pkt_start;
	logic take;
	logic advance;

	// bytes 1 and 2 of the packet whose sync byte sits in stage two
	assign pm.pid_hi = data_d1;
	assign pm.pid_lo = ts_data;

	assign pkt_start = ts_valid && !base_data && sync_d2 && (data_d2 == sync_byte);
	assign take = pkt_start && pm.hit;
	assign pm.accept = take;

	assign advance = ts_valid && (state == st_match) && (int'(position) < pkt_bytes);
	assign emit = base_data || ((state == st_match) && (int'(position) < pkt_bytes));
	assign matched = (state != st_idle);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else if (base_data) begin
			state <= st_pass;
		end else if (pkt_start) begin
			// a miss drops the packet
			state <= pm.hit ? st_match : st_idle;
		end else if (state == st_pass) begin
			state <= st_idle;
		end
	end

	// position restarts on the new packet even while the last byte goes out
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			position <= '0;
			change_pid <= 1'b0;
			pts_insert <= 1'b0;
			group <= '0;
			matched_count <= '0;
		end else if (take) begin
			position <= '0;
			change_pid <= pm.change_pid;
			pts_insert <= pm.pts_insert;
			group <= pm.group;
			matched_count <= matched_count + 1'b1;
		end else if (advance) begin
			position <= position + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pts_latched <= slot_pts;
		end
	end

endmodule

//--- replace_engine/replace_ram.sv
`timescale 1ns/1ps

module replace_ram import ts_replace_pkg::*; #(
	parameter int DATA_GROUPS = 2
) (
	input logic clk,
	input logic data_write,
	input logic [$clog2(pkt_words * DATA_GROUPS)-1:0] data_index,
	input logic [data_w-1:0] data_word,
	input logic [grp_w-1:0] group,
	input logic [pos_w-1:0] position,
	output logic [7:0] ram_byte
);

	localparam int depth = pkt_words * DATA_GROUPS;
	localparam int byte_addr_w = $clog2(pkt_bytes * DATA_GROUPS + 1);

	logic [data_w-1:0] mem [depth];
	logic [byte_addr_w-1:0] byte_addr;
	logic [data_w-1:0] word;

	always_ff @(posedge clk) begin
		if (data_write && (int'(data_index) < depth)) begin
			mem[data_index] <= data_word;
		end
	end

	assign byte_addr = byte_addr_w'(group) * byte_addr_w'(pkt_bytes) + byte_addr_w'(position);

	// position 188 of the last group points past the end
	assign word = (int'(byte_addr[byte_addr_w-1:2]) < depth) ?
		mem[byte_addr[byte_addr_w-1:2]] : '0;
	assign ram_byte = word[8 * byte_addr[1:0] +: 8];

endmodule

//--- rtl/pid_table.sv
`timescale 1ns/1ps

module pid_table import ts_replace_pkg::*; #(
	parameter int PID_SLOTS = 4,
	parameter int DATA_GROUPS = 2
) (
	input logic clk,
	input logic rst_n,
	input logic cfg_write,
	input logic [((PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1)-1:0] cfg_index,
	input pid_cfg_u cfg_word,
	input logic match_enable,
	pid_match_if.tbl pm
);

	localparam int slot_w = (PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1;

	pid_cfg_u cfg [PID_SLOTS];
	logic [grp_w-1:0] grp_cnt [PID_SLOTS];

	logic [pid_w-1:0] cand_pid;
	logic [PID_SLOTS-1:0] hits;
	logic [slot_w-1:0] sel;

	// PID is the low five bits of byte 1 and all of byte 2
	assign cand_pid = {pm.pid_hi[4:0], pm.pid_lo};

	// all slots compared at once
	always_comb begin
		for (int i = 0; i < PID_SLOTS; i++) begin
			hits[i] = ((cfg[i].f.match_en && match_enable) || (grp_cnt[i] != '0)) &&
				(cfg[i].f.pid == cand_pid);
		end
	end

	// highest matching slot wins
	always_comb begin
		sel = '0;
		for (int i = 0; i < PID_SLOTS; i++) begin
			if (hits[i]) begin
				sel = slot_w'(i);
			end
		end
	end

	assign pm.hit = |hits;
	assign pm.slot = sel;
	assign pm.change_pid = cfg[sel].f.change_pid;
	assign pm.pts_insert = cfg[sel].f.pts_insert;
	assign pm.group = grp_cnt[sel];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				cfg[i].raw <= '0;
				grp_cnt[i] <= '0;
			end
		end else begin
			if (cfg_write && (int'(cfg_index) < PID_SLOTS)) begin
				cfg[cfg_index].raw <= cfg_word.raw;
			end
			// rotate through the data groups of the accepted slot
			if (pm.accept) begin
				if (int'(grp_cnt[sel]) >= DATA_GROUPS - 1) begin
					grp_cnt[sel] <= '0;
				end else begin
					grp_cnt[sel] <= grp_cnt[sel] + 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/pts_ticker.sv
`timescale 1ns/1ps

module pts_ticker import ts_replace_pkg::*; #(
	parameter int PID_SLOTS = 4,
	parameter int PTS_PERIOD = 1000
) (
	input logic clk,
	input logic rst_n,
	input logic pts_write,
	input logic [((PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1)-1:0] pts_index,
	input logic [pts_w-1:0] pts_value,
	input logic [((PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1)-1:0] slot,
	output logic [pts_w-1:0] slot_pts
);

	localparam int cnt_w = $clog2(PTS_PERIOD + 1);

	logic [cnt_w-1:0] period_cnt;
	logic tick;
	logic [pts_w-1:0] pts_reg [PID_SLOTS];

	// one tick every PTS_PERIOD clocks
	assign tick = (period_cnt == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			period_cnt <= cnt_w'(PTS_PERIOD - 1);
		end else if (tick) begin
			period_cnt <= cnt_w'(PTS_PERIOD - 1);
		end else begin
			period_cnt <= period_cnt - 1'b1;
		end
	end

	// host load wins over the tick for its own slot only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				pts_reg[i] <= '0;
			end
		end else begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				if (pts_write && (int'(pts_index) == i)) begin
					pts_reg[i] <= pts_value;
				end else if (tick) begin
					pts_reg[i] <= pts_reg[i] + 1'b1;
				end
			end
		end
	end

	assign slot_pts = pts_reg[slot];

endmodule

//--- rtl/ts_replacer_top.sv
`timescale 1ns/1ps

module ts_replacer_top import ts_replace_pkg::*; #(
	parameter int PID_SLOTS = 4,
	parameter int DATA_GROUPS = 2,
	parameter int PTS_PERIOD = 1000
) (
	input logic clk,
	input logic rst_n,
	// host writes
	input logic cfg_write,
	input logic [((PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1)-1:0] cfg_index,
	input logic [data_w-1:0] cfg_word,
	input logic pts_write,
	input logic [((PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1)-1:0] pts_index,
	input logic [pts_w-1:0] pts_value,
	input logic data_write,
	input logic [$clog2(pkt_words * DATA_GROUPS)-1:0] data_index,
	input logic [data_w-1:0] data_word,
	// control
	input logic match_enable,
	input logic base_data,
	// stream in
	input logic [7:0] ts_data,
	input logic ts_valid,
	input logic ts_sync,
	// stream out
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync,
	// status
	output logic matched_state,
	output logic [data_w-1:0] matched_count
);

	logic sync_d2;
	logic [7:0] data_d2;
	logic [7:0] data_d1;
	logic [pos_w-1:0] position;
	logic emit;
	logic change_pid;
	logic pts_insert;
	logic [grp_w-1:0] group;
	logic [pts_w-1:0] pts_latched;
	logic [pts_w-1:0] slot_pts;
	logic [7:0] ram_byte;

	pid_match_if #(.PID_SLOTS(PID_SLOTS)) pm ();

	pid_table #(
		.PID_SLOTS(PID_SLOTS),
		.DATA_GROUPS(DATA_GROUPS)
	) u_pid_table (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_write(cfg_write),
		.cfg_index(cfg_index),
		.cfg_word(cfg_word),
		.match_enable(match_enable),
		.pm(pm.tbl)
	);

	pts_ticker #(
		.PID_SLOTS(PID_SLOTS),
		.PTS_PERIOD(PTS_PERIOD)
	) u_pts_ticker (
		.clk(clk),
		.rst_n(rst_n),
		.pts_write(pts_write),
		.pts_index(pts_index),
		.pts_value(pts_value),
		.slot(pm.slot),
		.slot_pts(slot_pts)
	);

	packet_fsm #(.DATA_GROUPS(DATA_GROUPS)) u_packet_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.ts_valid(ts_valid),
		.base_data(base_data),
		.sync_d2(sync_d2),
		.data_d2(data_d2),
		.data_d1(data_d1),
		.ts_data(ts_data),
		.slot_pts(slot_pts),
		.position(position),
		.emit(emit),
		.matched(matched_state),
		.change_pid(change_pid),
		.pts_insert(pts_insert),
		.group(group),
		.pts_latched(pts_latched),
		.matched_count(matched_count),
		.pm(pm.fsm)
	);

	byte_rewriter u_byte_rewriter (
		.clk(clk),
		.rst_n(rst_n),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.position(position),
		.emit(emit),
		.base_data(base_data),
		.change_pid(change_pid),
		.pts_insert(pts_insert),
		.group(group),
		.pts_latched(pts_latched),
		.ram_byte(ram_byte),
		.sync_d2(sync_d2),
		.data_d2(data_d2),
		.data_d1(data_d1),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid),
		.ts_out_sync(ts_out_sync)
	);

	replace_ram #(.DATA_GROUPS(DATA_GROUPS)) u_replace_ram (
		.clk(clk),
		.data_write(data_write),
		.data_index(data_index),
		.data_word(data_word),
		.group(group),
		.position(position),
		.ram_byte(ram_byte)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ts_replacer -f ts_replacer.f \
	&& ./obj_dir/Vtb_ts_replacer > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation passed" sim.log && exit 0 || exit 1

//--- ts_replacer.f
+incdir+bench
common/ts_replace_pkg.sv
common/pid_match_if.sv
rtl/pid_table.sv
rtl/pts_ticker.sv
replace_engine/packet_fsm.sv
replace_engine/byte_rewriter.sv
replace_engine/replace_ram.sv
rtl/ts_replacer_top.sv
bench/tb_ts_replacer.sv
